//--- src/obcBusPkg.sv
`default_nettype none

package obcBusPkg;

    // Full 24-bit CPU bus address
    typedef logic [23:0] obcCpuAddrT;

    // Window view of the low 13 address bits
    typedef struct packed {
        logic [9:0] tag;         // Window test
        logic [2:0] sel;         // Slot inside 7FF0-7FF7
    } obcWindowT;

    // Low CPU address, seen either as a direct RAM address or as a window slot
    typedef union packed {
        logic [12:0] sramAddr;   // Plain view
        obcWindowT   window;     // Window view
    } obcAddrU;

    localparam logic [11:0] RegPage   = 12'h7FF;         // CA[15:4] of the register page
    localparam logic [9:0]  WindowTag = 10'b1111111110;  // 7FF0-7FF7 in the 13-bit view

    localparam logic [2:0]  SelBits   = 3'd4;            // 7FF4 packed field
    localparam logic [2:0]  SelBase   = 3'd5;            // 7FF5 BASE
    localparam logic [2:0]  SelIndex  = 3'd6;            // 7FF6 INDEX

endpackage

`default_nettype wire

//--- src/obcMapPkg.sv
`default_nettype none

package obcMapPkg;

    // What a single bus access turns into
    typedef enum logic [2:0] {
        kindPlain,      // Direct RAM access
        kindAttrByte,   // 7FF0-7FF3, record byte
        kindAttrBits,   // 7FF4, packed 2-bit field
        kindRegBase,    // 7FF5
        kindRegIndex    // 7FF6
    } obcKindE;

    // Attribute table layout inside the 8 KB RAM
    // {TableTop, ~BASE, area, offset}
    localparam logic [1:0] TableTop = 2'b11;
    localparam logic       ByteArea = 1'b0;   // 512-byte record area
    localparam logic       BitsArea = 1'b1;   // 32-byte packed area

    localparam int SramWords = 8192;          // RAM depth

endpackage

`default_nettype wire

//--- src/obcAccessIf.sv
`timescale 1ns/1ps
`default_nettype none

interface obcAccessIf;
    import obcBusPkg::*;
    import obcMapPkg::*;

    obcKindE    kind;         // Classified access
    obcAddrU    addr;         // Low CPU address
    logic [7:0] data;         // Write data from the bus
    logic       wrPulse;      // Bus write taking effect
    logic       regWrPulse;   // Write on the register page with enable

    modport decoder (
        output kind,
        output addr,
        output data,
        output wrPulse,
        output regWrPulse
    );

    // Register loads need the bus data as well
    modport execute (
        input kind,
        input addr,
        input data,
        input regWrPulse
    );

    modport result (
        input kind,
        input data,
        input wrPulse
    );

endinterface

`default_nettype wire

//--- src/obcDecode.sv
`timescale 1ns/1ps
`default_nettype none

module obcDecode (
    input  obcBusPkg::obcCpuAddrT ca,
    input  logic [7:0]            di,
    input  logic                  cpuWrN,
    input  logic                  cs,
    input  logic                  sysclkfCe,
    input  logic                  enable,
    obcAccessIf.decoder           acc
);
    import obcBusPkg::*;
    import obcMapPkg::*;

    obcAddrU lowAddr;
    logic    inWindow;
    logic    onRegPage;
    logic    wrPulse;
    obcKindE kind;

    assign lowAddr   = ca[12:0];
    assign inWindow  = (lowAddr.window.tag == WindowTag);   // Any mirror of 7FF0-7FF7
    assign onRegPage = (ca[15:4] == RegPage);

    always_comb begin
        kind = kindPlain;
        if (inWindow) begin
            case (lowAddr.window.sel)
                3'd0, 3'd1, 3'd2, 3'd3: begin
                    kind = kindAttrByte;
                end
                SelBits: begin
                    kind = kindAttrBits;
                end
                SelBase: begin
                    if (onRegPage) begin
                        kind = kindRegBase;
                    end
                end
                SelIndex: begin
                    if (onRegPage) begin
                        kind = kindRegIndex;
                    end
                end
                default: begin
                    kind = kindPlain;
                end
            endcase
        end
    end

    assign wrPulse = cs && !cpuWrN && sysclkfCe;

    assign acc.kind       = kind;
    assign acc.addr       = lowAddr;
    assign acc.data       = di;
    assign acc.wrPulse    = wrPulse;
    assign acc.regWrPulse = wrPulse && enable && onRegPage;  // RAM writes ignore enable

endmodule

`default_nettype wire

//--- src/obcExecute.sv
`timescale 1ns/1ps
`default_nettype none

module obcExecute (
    input  logic         CLK,
    input  logic         RST_N,
    obcAccessIf.execute  acc,
    output logic [12:0]  sramAddr,
    output logic [1:0]   bitPos
);
    import obcMapPkg::*;

    logic       base;    // Table select, 0 picks the upper table
    logic [6:0] index;   // Object number

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            base  <= 1'b0;
            index <= 7'd0;
        end else if (acc.regWrPulse) begin
            case (acc.kind)
                kindRegBase: begin
                    base <= acc.data[0];
                end
                kindRegIndex: begin
                    index <= acc.data[6:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Remap window accesses into the selected table
    always_comb begin
        case (acc.kind)
            kindAttrByte: begin
                sramAddr = {TableTop, ~base, ByteArea, index,
                            acc.addr.window.sel[1:0]};
            end
            kindAttrBits: begin
                sramAddr = {TableTop, ~base, BitsArea, 4'b0000, index[6:2]};  // Four objects per byte
            end
            default: begin
                sramAddr = acc.addr.sramAddr;
            end
        endcase
    end

    assign bitPos = index[1:0];   // Pair inside the packed byte

endmodule

`default_nettype wire

//--- src/obcResult.sv
`timescale 1ns/1ps
`default_nettype none

module obcResult (
    input  logic         CLK,
    obcAccessIf.result   acc,
    input  logic [12:0]  sramAddr,
    input  logic [1:0]   bitPos,
    output logic [7:0]   dout
);
    import obcMapPkg::*;

    logic [7:0] mem [SramWords];   // Attribute RAM
    logic [7:0] stored;
    logic [7:0] wrByte;

    // Zero-cycle read path
    assign stored = mem[sramAddr];
    assign dout   = stored;

    // Packed field writes replace one bit pair and keep the other three
    always_comb begin
        wrByte = acc.data;
        if (acc.kind == kindAttrBits) begin
            wrByte = stored;
            wrByte[{bitPos, 1'b0} +: 2] = acc.data[1:0];
        end
    end

    always_ff @(posedge CLK) begin
        if (acc.wrPulse) begin
            mem[sramAddr] <= wrByte;
        end
    end

endmodule

`default_nettype wire

//--- src/obcSystem.sv
`timescale 1ns/1ps
`default_nettype none

module obcSystem (
    input  logic        CLK,
    input  logic        RST_N,
    input  logic        enable,
    input  logic [23:0] ca,
    input  logic [7:0]  di,
    input  logic        cpuWrN,
    input  logic        sysclkfCe,
    input  logic        cs,
    output logic [7:0]  dout
);

    logic [12:0] sramAddr;
    logic [1:0]  bitPos;

    obcAccessIf acc ();

    obcDecode decode_i (
        .ca        (ca),
        .di        (di),
        .cpuWrN    (cpuWrN),
        .cs        (cs),
        .sysclkfCe (sysclkfCe),
        .enable    (enable),
        .acc       (acc.decoder)
    );

    obcExecute execute_i (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .acc      (acc.execute),
        .sramAddr (sramAddr),
        .bitPos   (bitPos)
    );

    obcResult result_i (
        .CLK      (CLK),
        .acc      (acc.result),
        .sramAddr (sramAddr),
        .bitPos   (bitPos),
        .dout     (dout)
    );

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic CLK,
    output logic RST_N
);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;   // 20 ns period
    end

    initial begin
        RST_N = 1'b0;
        repeat (8) @(negedge CLK);   // Covers eight rising edges
        RST_N = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/obcScoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module obcScoreboard (
    input  logic        CLK,
    input  logic        RST_N,
    input  logic        enable,
    input  logic [23:0] ca,
    input  logic [7:0]  di,
    input  logic        cpuWrN,
    input  logic        sysclkfCe,
    input  logic        cs,
    input  logic [7:0]  dout,
    output int          errorCount,
    output int          checkCount
);
    import obcMapPkg::*;

    logic [7:0] ramModel [SramWords];
    logic       known    [SramWords];   // Byte has a defined value
    logic       baseModel;
    logic [6:0] indexModel;

    // RAM address a bus access should reach
    function automatic logic [12:0] targetAddr(input logic [23:0] a, input logic b,
                                               input logic [6:0] idx);
        int tableStart;
        int slot;
        int word;
        tableStart = b ? 'h1800 : 'h1C00;   // BASE 1 picks the lower table
        slot = int'(a[2:0]);
        if (a[12:3] != 10'h3FE || slot > 4) begin
            word = int'(a[12:0]);
        end else if (slot == 4) begin
            word = tableStart + 'h200 + int'(idx) / 4;   // Four objects per packed byte
        end else begin
            word = tableStart + int'(idx) * 4 + slot;
        end
        return word[12:0];
    endfunction

    function automatic logic [7:0] mergePair(input logic [7:0] old, input logic [7:0] d,
                                             input logic [1:0] pos);
        logic [7:0] mask;
        mask = 8'h03 << (2 * pos);
        return (old & ~mask) | ((d & 8'h03) << (2 * pos));
    endfunction

    initial begin
        logic [12:0] a;
        errorCount = 0;
        checkCount = 0;
        baseModel  = 1'b0;
        indexModel = 7'd0;
        for (int i = 0; i < SramWords; i++) begin
            known[i] = 1'b0;
        end
        forever begin
            @(posedge CLK);
            a = targetAddr(ca, baseModel, indexModel);
            if (known[a]) begin
                checkCount++;
                if (dout !== ramModel[a]) begin
                    errorCount++;
                    $display("[FAIL] %0t ns: dout expected %02h, actual %02h (RAM %04h)",
                             $time, ramModel[a], dout, a);
                end
            end
            if (!RST_N) begin
                baseModel  = 1'b0;
                indexModel = 7'd0;
            end else if (cs && !cpuWrN && sysclkfCe) begin
                if (ca[12:0] == 13'h1FF4) begin
                    if (known[a]) begin
                        ramModel[a] = mergePair(ramModel[a], di, indexModel[1:0]);
                    end
                end else begin
                    ramModel[a] = di;
                    known[a]    = 1'b1;
                end
                if (enable && ca[15:4] == 12'h7FF && ca[3:0] == 4'h5) begin
                    baseModel = di[0];
                end
                if (enable && ca[15:4] == 12'h7FF && ca[3:0] == 4'h6) begin
                    indexModel = di[6:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/obcSystem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module obcSystem_checker (
    input logic               CLK,
    input logic               RST_N,
    input logic               wrPulse,
    input logic               regWrPulse,
    input obcMapPkg::obcKindE kind,
    input logic [6:0]         index
);
    import obcMapPkg::*;

    int assertFails = 0;

    quietInReset: assert property (@(posedge CLK) !RST_N |-> !wrPulse && !regWrPulse)
        else begin
            $error("write strobe active while reset is held");
            assertFails++;
        end

    regNeedsWrite: assert property (@(posedge CLK) regWrPulse |-> wrPulse)
        else begin
            $error("register strobe without a bus write");
            assertFails++;
        end

    // Reset itself also clears INDEX
    indexOnWrite: assert property (@(posedge CLK) disable iff (!RST_N)
        (index != $past(index)) |-> $past(!RST_N || (regWrPulse && kind == kindRegIndex)))
        else begin
            $error("INDEX changed without an index register write");
            assertFails++;
        end

endmodule

bind obcSystem obcSystem_checker chk_i (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .wrPulse    (acc.wrPulse),
    .regWrPulse (acc.regWrPulse),
    .kind       (acc.kind),
    .index      (execute_i.index)
);

`default_nettype wire

//--- testbench/tbTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbTop;
    localparam int NumTests        = 6;
    localparam int AccessesPerTest = 64;
    localparam int WatchdogNs      = (NumTests * AccessesPerTest + 100) * 20;

    logic        CLK;
    logic        porRstN;
    logic        testRstN;
    logic        RST_N;
    logic        enable;
    logic [23:0] ca;
    logic [7:0]  di;
    logic        cpuWrN;
    logic        sysclkfCe;
    logic        cs;
    logic [7:0]  dout;
    int          errorCount;
    int          checkCount;
    int          testsFailed;
    int          lastErrors;
    int          idx;
    int          a;
    logic [31:0] lfsr;
    logic [31:0] r;

    assign RST_N = porRstN && testRstN;

    tbClock clock_i (
        .CLK   (CLK),
        .RST_N (porRstN)
    );

    obcSystem dut_i (.*);

    obcScoreboard sb_i (.*);

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);   // Galois form
    endfunction

    task automatic takeBits(input int n);
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    function automatic int totalErrors();
        return errorCount + dut_i.chk_i.assertFails;
    endfunction

    task automatic busCycle(input int addr, input logic [7:0] d, input logic wr,
                            input logic en, input logic ce, input logic sel);
        @(negedge CLK);
        ca        = addr[23:0];
        di        = d;
        cpuWrN    = !wr;
        enable    = en;
        sysclkfCe = ce;
        cs        = sel;
    endtask

    task automatic writeAt(input int addr, input logic [7:0] d);
        busCycle(addr, d, 1'b1, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic readAt(input int addr);
        busCycle(addr, 8'h00, 1'b0, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic idleCycle();
        busCycle(0, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic endTest(input string name);
        int errs;
        idleCycle();   // Last access gets compared first
        errs = totalErrors() - lastErrors;
        lastErrors += errs;
        if (errs != 0) begin
            testsFailed++;
        end
        $display("Test %-7s %s, %0d mismatches", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        #(WatchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        lfsr        = 32'h7f6c70d5;
        testRstN    = 1'b1;
        enable      = 1'b1;
        ca          = 24'd0;
        di          = 8'd0;
        cpuWrN      = 1'b1;
        sysclkfCe   = 1'b1;
        cs          = 1'b0;
        testsFailed = 0;
        lastErrors  = 0;
        wait (RST_N == 1'b1);

        for (int i = 0; i < 16; i++) begin
            takeBits(12);
            a = int'(r[11:0]);   // Bit 12 clear keeps clear of the window
            takeBits(11);
            a = a | (int'(r[10:0]) << 13);
            takeBits(8);
            writeAt(a, r[7:0]);
            takeBits(11);
            readAt((a & 'h1FFF) | (int'(r[10:0]) << 13));   // Other mirror
        end
        endTest("plain");

        for (int k = 0; k < 2; k++) begin
            takeBits(7);
            idx = int'(r[6:0]);
            writeAt('h7FF6, r[7:0]);
            for (int s = 0; s < 4; s++) begin
                takeBits(8);
                writeAt('h7FF0 + s, r[7:0]);
            end
            for (int s = 0; s < 8; s++) begin
                readAt((s < 4) ? 'h7FF0 + s : 'h1C00 + idx * 4 + s - 4);
            end
        end
        endTest("record");

        takeBits(5);
        idx = int'(r[4:0]);
        takeBits(8);
        writeAt('h1E00 + idx, r[7:0]);
        for (int p = 0; p < 4; p++) begin
            writeAt('h7FF6, 8'(idx * 4 + p));
            takeBits(8);
            writeAt('h7FF4, r[7:0]);   // Upper bits must be ignored
            readAt('h7FF4);
            readAt('h1E00 + idx);
        end
        endTest("packed");

        takeBits(7);
        idx = int'(r[6:0]);
        writeAt('h7FF6, r[7:0]);
        for (int b = 0; b < 2; b++) begin
            writeAt('h7FF5, 8'(b));
            takeBits(8);
            writeAt('h7FF0, r[7:0]);
            readAt('h7FF0);
        end
        writeAt('h7FF5, 8'h00);
        readAt('h7FF0);
        readAt('h1C00 + idx * 4);
        readAt('h1800 + idx * 4);
        endTest("table");

        writeAt('h7FF6, 8'h11);
        writeAt('h7FF0, 8'hA5);
        busCycle('h7FF6, 8'h22, 1'b1, 1'b0, 1'b1, 1'b1);   // enable low
        readAt('h7FF0);
        readAt('h1FF6);
        busCycle('h7FF6, 8'h33, 1'b1, 1'b1, 1'b0, 1'b1);   // No clock enable
        readAt('h7FF0);
        writeAt('h0123, 8'h5A);
        busCycle('h0123, 8'hC3, 1'b1, 1'b1, 1'b1, 1'b0);   // Not selected
        readAt('h0123);
        busCycle('h0456, 8'h69, 1'b1, 1'b0, 1'b1, 1'b1);
        readAt('h0456);
        endTest("gating");

        writeAt('h7FF5, 8'h01);
        writeAt('h7FF6, 8'h45);
        writeAt('h1E00, 8'hFF);
        idleCycle();
        testRstN = 1'b0;
        repeat (3) idleCycle();
        testRstN = 1'b1;
        writeAt('h7FF0, 8'h3C);
        writeAt('h7FF4, 8'h02);
        readAt('h1C00);
        readAt('h1E00);
        endTest("reset");

        $display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
                 NumTests, testsFailed, checkCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/obcBusPkg.sv
src/obcMapPkg.sv
src/obcAccessIf.sv
src/obcDecode.sv
src/obcExecute.sv
src/obcResult.sv
src/obcSystem.sv
testbench/tbClock.sv
testbench/obcScoreboard.sv
testbench/obcSystem_checker.sv
testbench/tbTop.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tbTop -f tb.f -o simTop
./obj_dir/simTop +verilator+error+limit+1000 | tee sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
